// ==== Makefile ====
.PHONY: all run lint clean

all: run

obj_dir/Vtb_wb_fabric: all.f *.sv
	verilator --binary --timing --assert -f all.f --top-module tb_wb_fabric -Mdir obj_dir

run: obj_dir/Vtb_wb_fabric
	@out="$$(./obj_dir/Vtb_wb_fabric)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

lint:
	verilator --lint-only --timing --assert -f all.f --top-module tb_wb_fabric

clean:
	rm -rf obj_dir

// ==== all.f ====
fabric_pkg.sv
wb_fabric_ctrl.sv
sim_mem.sv
irq_trigger.sv
wb_sim_fabric_top.sv
wb_fabric_chk.sv
tb_wb_fabric.sv

// ==== fabric_pkg.sv ====
// --------------------------------------
// wishbone fabric shared definitions
// --------------------------------------

package fabric_pkg;

    // bus geometry --------------------------
    localparam int ADDR_W = 32;                 // byte address width
    localparam int DATA_W = 32;                 // data word width
    localparam int SEL_W  = DATA_W / 8;         // one enable per byte lane

    typedef logic [ADDR_W-1:0] addr_t;          // bus address
    typedef logic [DATA_W-1:0] data_t;          // bus data word
    typedef logic [SEL_W-1:0]  sel_t;           // byte enables

    // address decode ------------------------
    // target picked by the address decoder, REGION_NONE means nobody answers
    typedef enum logic [1:0] {
        REGION_NONE = 2'd0,                     // unmapped, access times out
        REGION_DMEM = 2'd1,                     // data memory window
        REGION_IO   = 2'd2,                     // io scratch memory window
        REGION_IRQ  = 2'd3                      // interrupt trigger register
    } region_e;

    // interrupt trigger ---------------------
    localparam int MSI_BIT = 3;                 // wdata bit for machine software irq
    localparam int MEI_BIT = 11;                // wdata bit for machine external irq

endpackage : fabric_pkg

// ==== irq_trigger.sv ====
// --------------------------------------
// interrupt trigger register
// --------------------------------------

module irq_trigger (
    input  logic              clk_gen,
    input  logic              rst_gen,   // async, active low
    input  logic              cyc_i,
    input  logic              stb_i,     // high only at the trigger address
    input  logic              we_i,
    input  fabric_pkg::sel_t  sel_i,
    input  fabric_pkg::data_t wdata_i,
    output fabric_pkg::data_t rdata_o,   // write only register
    output logic              ack_o,
    output logic              msi_o,     // machine software interrupt
    output logic              mei_o      // machine external interrupt
);

    logic wr_hit;                           // full word write to the register

    // reads and partial writes are ignored and never acked
    assign wr_hit  = cyc_i & stb_i & we_i & (&sel_i);
    assign rdata_o = '0;                    // nothing to read back

    always_ff @(posedge clk_gen or negedge rst_gen) begin
        if (rst_gen == 1'b0) begin
            ack_o <= 1'b0;
            msi_o <= 1'b0;
            mei_o <= 1'b0;
        end else begin
            ack_o <= wr_hit;                // single cycle response
            if (wr_hit) begin
                msi_o <= wdata_i[fabric_pkg::MSI_BIT]; // lines follow the written word
                mei_o <= wdata_i[fabric_pkg::MEI_BIT];
            end
        end
    end

endmodule : irq_trigger

// ==== sim_mem.sv ====
// --------------------------------------
// simulated wishbone memory
// --------------------------------------

module sim_mem #(
    parameter fabric_pkg::addr_t BASE    = 32'h8000_0000, // window base address
    parameter int                SIZE    = 8 * 1024,      // window size in bytes
    parameter int                LATENCY = 8              // extra delay, 1 to 255
) (
    input  logic              clk_gen,
    input  logic              rst_gen,   // async, active low
    input  logic              cyc_i,
    input  logic              stb_i,     // only high when the window is hit
    input  logic              we_i,
    input  fabric_pkg::addr_t addr_i,
    input  fabric_pkg::sel_t  sel_i,
    input  fabric_pkg::data_t wdata_i,
    output fabric_pkg::data_t rdata_o,   // zero while ack_o is low
    output logic              ack_o
);

    localparam int WORDS = SIZE / 4;                              // 32 bit words
    localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;       // word index width

    fabric_pkg::data_t      mem [WORDS];       // storage, contents undefined at start
    fabric_pkg::data_t      rd_pipe [LATENCY]; // read data delay chain
    logic [LATENCY-1:0]     ack_pipe;          // acknowledge delay chain
    fabric_pkg::addr_t      offset;            // byte offset inside the window
    logic [IDX_W-1:0]       word_idx;          // word aligned index
    logic                   wr_en;

    assign offset   = addr_i - BASE;
    assign word_idx = offset[IDX_W+1:2];      // drop byte lane bits
    assign wr_en    = cyc_i & stb_i & we_i;

    // write port and read data chain --------
    always_ff @(posedge clk_gen) begin
        if (wr_en) begin
            for (int b = 0; b < fabric_pkg::SEL_W; b++) begin
                if (sel_i[b]) begin
                    mem[word_idx][b*8 +: 8] <= wdata_i[b*8 +: 8]; // byte lane write
                end
            end
        end
        rd_pipe[0] <= mem[word_idx];          // read every cycle, ack decides use
        for (int i = 1; i < LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    // acknowledge chain and bus output ------
    always_ff @(posedge clk_gen or negedge rst_gen) begin
        if (rst_gen == 1'b0) begin
            ack_pipe <= '0;
            ack_o    <= 1'b0;
            rdata_o  <= '0;
        end else begin
            ack_pipe[0] <= cyc_i & stb_i;     // request sampled
            for (int i = 1; i < LATENCY; i++) begin
                ack_pipe[i] <= ack_pipe[i-1] & cyc_i; // dropping cyc flushes in-flight acks
            end
            // output stage, gated so the OR merge upstream stays clean
            if (ack_pipe[LATENCY-1] && cyc_i) begin
                rdata_o <= rd_pipe[LATENCY-1];
                ack_o   <= 1'b1;
            end else begin
                rdata_o <= '0;
                ack_o   <= 1'b0;
            end
        end
    end

endmodule : sim_mem

// ==== tb_wb_fabric.sv ====
// --------------------------------------
// wishbone fabric testbench
// --------------------------------------

module tb_wb_fabric;

    timeunit 1ns;
    timeprecision 1ns;

    localparam fabric_pkg::addr_t DMEM_BASE    = 32'h8000_0000;
    localparam int                DMEM_SIZE    = 256;          // bytes
    localparam int                DMEM_LATENCY = 4;
    localparam fabric_pkg::addr_t IO_BASE      = 32'hf000_0000;
    localparam int                IO_SIZE      = 32;           // bytes
    localparam int                IO_LATENCY   = 8;
    localparam fabric_pkg::addr_t IRQ_ADDR     = 32'hff00_0000;
    localparam int                NUM_VEC      = 26;

    // one bus access
    typedef struct packed {
        fabric_pkg::addr_t addr;
        logic              we;
        fabric_pkg::sel_t  sel;
        fabric_pkg::data_t data;                // zero draws a random word
        logic              exp_ack;
    } access_t;

    logic              clk_gen;
    logic              rst_gen;
    logic              cyc_i, stb_i, we_i;
    fabric_pkg::addr_t addr_i;
    fabric_pkg::sel_t  sel_i;
    fabric_pkg::data_t wdata_i;
    fabric_pkg::data_t rdata_o;
    logic              ack_o, msi_o, mei_o;

    logic [7:0]        byte_model [fabric_pkg::addr_t]; // expected memory bytes
    logic              exp_msi, exp_mei;                 // expected interrupt lines
    logic [31:0]       rng_state;
    int                error_count, test_count, fail_count;

    // stimulus table ------------------------
    access_t vectors [NUM_VEC] = '{
        '{32'h8000_0000, 1'b1, 4'hf, 32'h0000_0000, 1'b1}, // full word into data memory
        '{32'h8000_0000, 1'b1, 4'h5, 32'h0000_0000, 1'b1}, // byte lanes 0 and 2
        '{32'h8000_00fc, 1'b1, 4'hf, 32'h0000_0000, 1'b1}, // last word of the window
        '{32'h8000_00fc, 1'b1, 4'h2, 32'h0000_0000, 1'b1},
        '{32'h8000_0010, 1'b1, 4'hc, 32'h0000_0000, 1'b1}, // upper half only
        '{32'h8000_0000, 1'b0, 4'hf, 32'h0000_0000, 1'b1},
        '{32'h8000_00fc, 1'b0, 4'hf, 32'h0000_0000, 1'b1},
        '{32'h8000_0010, 1'b0, 4'hf, 32'h0000_0000, 1'b1},
        '{32'hf000_0000, 1'b1, 4'hf, 32'h0000_0000, 1'b1}, // io memory at the dmem offset
        '{32'hf000_0000, 1'b1, 4'ha, 32'h0000_0000, 1'b1},
        '{32'hf000_001c, 1'b1, 4'hf, 32'h0000_0000, 1'b1},
        '{32'hf000_0000, 1'b0, 4'hf, 32'h0000_0000, 1'b1},
        '{32'hf000_001c, 1'b0, 4'hf, 32'h0000_0000, 1'b1},
        '{32'h8000_0000, 1'b0, 4'hf, 32'h0000_0000, 1'b1}, // dmem untouched by io writes
        '{32'h8000_0000, 1'b1, 4'hf, 32'h0000_0000, 1'b1}, // dmem write over the io offset
        '{32'hf000_0000, 1'b0, 4'hf, 32'h0000_0000, 1'b1}, // io untouched by dmem writes
        '{32'hff00_0000, 1'b1, 4'hf, 32'h0000_0808, 1'b1}, // both lines up
        '{32'hff00_0000, 1'b1, 4'h7, 32'hffff_f7f7, 1'b0}, // partial write ignored
        '{32'hff00_0000, 1'b0, 4'hf, 32'h0000_0000, 1'b0}, // register is write only
        '{32'hff00_0000, 1'b1, 4'hf, 32'hffff_f7f7, 1'b1}, // both lines down
        '{32'hff00_0000, 1'b1, 4'hf, 32'h0000_0000, 1'b1},
        '{32'hff00_0000, 1'b1, 4'hf, 32'h0000_0000, 1'b1},
        '{32'h9000_0000, 1'b1, 4'hf, 32'h0000_0000, 1'b0}, // unmapped
        '{32'h8000_0100, 1'b0, 4'hf, 32'h0000_0000, 1'b0}, // one past dmem
        '{32'hf000_0020, 1'b0, 4'hf, 32'h0000_0000, 1'b0}, // one past io
        '{32'hff00_0004, 1'b0, 4'hf, 32'h0000_0000, 1'b0}  // next to the trigger
    };

    wb_sim_fabric_top #(
        .DMEM_BASE    (DMEM_BASE),
        .DMEM_SIZE    (DMEM_SIZE),
        .DMEM_LATENCY (DMEM_LATENCY),
        .IO_BASE      (IO_BASE),
        .IO_SIZE      (IO_SIZE),
        .IO_LATENCY   (IO_LATENCY),
        .IRQ_ADDR     (IRQ_ADDR)
    ) i_dut (
        .clk_gen (clk_gen),
        .rst_gen (rst_gen),
        .cyc_i   (cyc_i),
        .stb_i   (stb_i),
        .we_i    (we_i),
        .addr_i  (addr_i),
        .sel_i   (sel_i),
        .wdata_i (wdata_i),
        .rdata_o (rdata_o),
        .ack_o   (ack_o),
        .msi_o   (msi_o),
        .mei_o   (mei_o)
    );

    always #20 clk_gen = ~clk_gen;                       // 40 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // edges from the first sampled request to ack (zero if nobody answers)
    function automatic int expected_latency(input fabric_pkg::addr_t addr);
        if ((addr >= DMEM_BASE) && (addr < DMEM_BASE + fabric_pkg::addr_t'(DMEM_SIZE))) begin
            return DMEM_LATENCY + 1;
        end
        if ((addr >= IO_BASE) && (addr < IO_BASE + fabric_pkg::addr_t'(IO_SIZE))) begin
            return IO_LATENCY + 1;
        end
        if (addr == IRQ_ADDR) begin
            return 1;
        end
        return 0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    // byte model word with a mask of the bytes written so far
    task automatic expected_word(input fabric_pkg::addr_t addr, output fabric_pkg::data_t data,
                                 output fabric_pkg::data_t mask);
        fabric_pkg::addr_t byte_addr;
        data = '0;
        mask = '0;
        for (int b = 0; b < fabric_pkg::SEL_W; b++) begin
            byte_addr = addr + fabric_pkg::addr_t'(b);
            if (byte_model.exists(byte_addr)) begin
                data[b*8 +: 8] = byte_model[byte_addr];
                mask[b*8 +: 8] = 8'hff;
            end
        end
    endtask

    // one table entry ------------------------
    task automatic run_access(input access_t acc, input int idx);
        fabric_pkg::data_t wdata;
        fabric_pkg::data_t exp_data;
        fabric_pkg::data_t mask;
        int                exp_lat;
        int                limit;
        int                edges;
        int                errors_before;
        bit                acked;
        string             kind;
        string             verdict;
        errors_before = error_count;
        wdata = acc.data;
        if (wdata == '0) begin
            rng_state = xorshift32(rng_state);
            wdata = rng_state;
        end
        exp_lat = expected_latency(acc.addr);
        limit = ((exp_lat > 0) ? exp_lat : 1) + 20;
        cyc_i = 1'b1;                                    // caller is on a falling edge
        stb_i = 1'b1;
        we_i = acc.we;
        addr_i = acc.addr;
        sel_i = acc.sel;
        wdata_i = wdata;
        edges = 0;
        acked = 1'b0;
        while (!acked && (edges < limit)) begin
            @(negedge clk_gen);
            edges++;
            if (ack_o) begin
                acked = 1'b1;
            end else begin
                check_value("rdata_o", rdata_o, '0);     // idle response stays zero
            end
        end
        if (acked && acc.exp_ack) begin
            check_value("ack_o latency", edges, exp_lat);
            if (!acc.we) begin
                expected_word(acc.addr, exp_data, mask);
                check_value("rdata_o", rdata_o & mask, exp_data & mask);
            end else if (acc.addr == IRQ_ADDR) begin
                exp_msi = wdata[fabric_pkg::MSI_BIT];
                exp_mei = wdata[fabric_pkg::MEI_BIT];
            end else begin
                for (int b = 0; b < fabric_pkg::SEL_W; b++) begin
                    if (acc.sel[b]) begin
                        byte_model[acc.addr + fabric_pkg::addr_t'(b)] = wdata[b*8 +: 8];
                    end
                end
            end
        end else if (acked) begin
            $display("Error at %0t ns: unexpected acknowledge for address %h", $time, acc.addr);
            error_count++;
        end else if (acc.exp_ack) begin
            $display("Error at %0t ns: no acknowledge for address %h within %0d cycles",
                     $time, acc.addr, limit);
            error_count++;
        end
        cyc_i = 1'b0;                                    // end the cycle
        stb_i = 1'b0;
        @(negedge clk_gen);                              // one idle cycle between transfers
        check_value("ack_o", 32'(ack_o), '0);
        check_value("msi_o", 32'(msi_o), 32'(exp_msi));
        check_value("mei_o", 32'(mei_o), 32'(exp_mei));
        test_count++;
        if (error_count != errors_before) begin
            fail_count++;
            verdict = "failed";
        end else begin
            verdict = "ok";
        end
        if (acc.we) begin
            kind = "write";
        end else begin
            kind = "read";
        end
        $display("test %0d %s %h: %s", idx, kind, acc.addr, verdict);
    endtask

    // main sequence --------------------------
    initial begin
        string verdict;
        clk_gen = 1'b0;
        rst_gen = 1'b0;
        cyc_i = 1'b0;
        stb_i = 1'b0;
        we_i = 1'b0;
        addr_i = '0;
        sel_i = '0;
        wdata_i = '0;
        exp_msi = 1'b0;
        exp_mei = 1'b0;
        rng_state = 32'hb4bac928;
        error_count = 0;
        test_count = 0;
        fail_count = 0;
        repeat (5) @(negedge clk_gen);
        rst_gen = 1'b1;
        @(negedge clk_gen);
        check_value("ack_o", 32'(ack_o), '0);            // quiet outputs after reset
        check_value("msi_o", 32'(msi_o), '0);
        check_value("mei_o", 32'(mei_o), '0);
        test_count++;
        if (error_count != 0) begin
            fail_count++;
            verdict = "failed";
        end else begin
            verdict = "ok";
        end
        $display("test reset: %s", verdict);
        for (int i = 0; i < NUM_VEC; i++) begin
            run_access(vectors[i], i);
        end
        $display("summary: %0d tests, %0d failed, %0d errors", test_count, fail_count,
                 error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : tb_wb_fabric

// ==== wb_fabric_chk.sv ====
// --------------------------------------
// fabric response checks
// --------------------------------------

module wb_fabric_chk (
    input logic              clk_gen,
    input logic              rst_gen,
    input logic              cyc_i,
    input logic              dmem_ack_i,
    input logic              io_ack_i,
    input logic              irq_ack_i,
    input logic              ack_i,      // merged ack from the decoder
    input fabric_pkg::data_t rdata_i     // merged read data from the decoder
);

    timeunit 1ns;
    timeprecision 1ns;

    // targets answer one at a time
    single_ack: assert property (@(posedge clk_gen) disable iff (!rst_gen)
        $onehot0({dmem_ack_i, io_ack_i, irq_ack_i}))
        else $error("more than one target acknowledged");

    // master drops cyc on the falling edge after it sees ack
    ack_in_cycle: assert property (@(posedge clk_gen) disable iff (!rst_gen)
        ack_i |-> (cyc_i || $past(cyc_i)))
        else $error("acknowledge outside a bus cycle");

    data_gated: assert property (@(posedge clk_gen) disable iff (!rst_gen)
        !ack_i |-> (rdata_i == '0))
        else $error("read data not zero without acknowledge");

endmodule : wb_fabric_chk

bind wb_sim_fabric_top wb_fabric_chk i_chk (
    .clk_gen    (clk_gen),
    .rst_gen    (rst_gen),
    .cyc_i      (cyc_i),
    .dmem_ack_i (dmem_ack),
    .io_ack_i   (io_ack),
    .irq_ack_i  (irq_ack),
    .ack_i      (ack_o),
    .rdata_i    (rdata_o)
);

// ==== wb_fabric_ctrl.sv ====
// --------------------------------------
// wishbone address decoder
// --------------------------------------

module wb_fabric_ctrl #(
    parameter fabric_pkg::addr_t DMEM_BASE = 32'h8000_0000, // data memory base
    parameter int                DMEM_SIZE = 8 * 1024,      // data memory bytes
    parameter fabric_pkg::addr_t IO_BASE   = 32'hf000_0000, // io memory base
    parameter int                IO_SIZE   = 32,            // io memory bytes
    parameter fabric_pkg::addr_t IRQ_ADDR  = 32'hff00_0000  // trigger register
) (
    input  fabric_pkg::addr_t addr_i,       // master address
    input  logic              stb_i,        // master strobe
    output logic              dmem_stb_o,   // strobe to data memory
    output logic              io_stb_o,     // strobe to io memory
    output logic              irq_stb_o,    // strobe to trigger register
    input  fabric_pkg::data_t dmem_rdata_i, // zero unless acking
    input  fabric_pkg::data_t io_rdata_i,
    input  fabric_pkg::data_t irq_rdata_i,
    input  logic              dmem_ack_i,
    input  logic              io_ack_i,
    input  logic              irq_ack_i,
    output fabric_pkg::data_t rdata_o,      // merged read data
    output logic              ack_o         // merged acknowledge
);

    // window limits, exclusive upper end
    localparam fabric_pkg::addr_t DMEM_END = DMEM_BASE + fabric_pkg::addr_t'(DMEM_SIZE);
    localparam fabric_pkg::addr_t IO_END   = IO_BASE + fabric_pkg::addr_t'(IO_SIZE);

    fabric_pkg::region_e region;            // decoded target of the current address

    // address decode ------------------------
    always_comb begin
        if ((addr_i >= DMEM_BASE) && (addr_i < DMEM_END)) begin
            region = fabric_pkg::REGION_DMEM;
        end else if ((addr_i >= IO_BASE) && (addr_i < IO_END)) begin
            region = fabric_pkg::REGION_IO;
        end else if (addr_i == IRQ_ADDR) begin
            region = fabric_pkg::REGION_IRQ; // single word, exact match
        end else begin
            region = fabric_pkg::REGION_NONE; // nobody claims it
        end
    end

    // strobe only reaches the selected target
    assign dmem_stb_o = stb_i && (region == fabric_pkg::REGION_DMEM);
    assign io_stb_o   = stb_i && (region == fabric_pkg::REGION_IO);
    assign irq_stb_o  = stb_i && (region == fabric_pkg::REGION_IRQ);

    // response merge ------------------------
    // targets gate their own outputs so a plain OR is enough here
    assign rdata_o = dmem_rdata_i | io_rdata_i | irq_rdata_i;
    assign ack_o   = dmem_ack_i | io_ack_i | irq_ack_i;

endmodule : wb_fabric_ctrl

// ==== wb_sim_fabric_top.sv ====
// --------------------------------------
// wishbone peripheral fabric
// --------------------------------------

module wb_sim_fabric_top #(
    parameter fabric_pkg::addr_t DMEM_BASE    = 32'h8000_0000, // data memory window
    parameter int                DMEM_SIZE    = 8 * 1024,
    parameter int                DMEM_LATENCY = 8,             // 1 to 255
    parameter fabric_pkg::addr_t IO_BASE      = 32'hf000_0000, // io scratch window
    parameter int                IO_SIZE      = 32,
    parameter int                IO_LATENCY   = 128,           // 1 to 255
    parameter fabric_pkg::addr_t IRQ_ADDR     = 32'hff00_0000  // trigger register
) (
    input  logic              clk_gen,
    input  logic              rst_gen,   // async, active low
    input  logic              cyc_i,
    input  logic              stb_i,
    input  logic              we_i,
    input  fabric_pkg::addr_t addr_i,
    input  fabric_pkg::sel_t  sel_i,
    input  fabric_pkg::data_t wdata_i,
    output fabric_pkg::data_t rdata_o,
    output logic              ack_o,
    output logic              msi_o,
    output logic              mei_o
);

    logic              dmem_stb, io_stb, irq_stb;      // per target strobes
    logic              dmem_ack, io_ack, irq_ack;      // per target acks
    fabric_pkg::data_t dmem_rdata, io_rdata, irq_rdata; // gated read data

    // decoder and response merge ------------
    wb_fabric_ctrl #(
        .DMEM_BASE (DMEM_BASE),
        .DMEM_SIZE (DMEM_SIZE),
        .IO_BASE   (IO_BASE),
        .IO_SIZE   (IO_SIZE),
        .IRQ_ADDR  (IRQ_ADDR)
    ) i_ctrl (
        .addr_i       (addr_i),
        .stb_i        (stb_i),
        .dmem_stb_o   (dmem_stb),
        .io_stb_o     (io_stb),
        .irq_stb_o    (irq_stb),
        .dmem_rdata_i (dmem_rdata),
        .io_rdata_i   (io_rdata),
        .irq_rdata_i  (irq_rdata),
        .dmem_ack_i   (dmem_ack),
        .io_ack_i     (io_ack),
        .irq_ack_i    (irq_ack),
        .rdata_o      (rdata_o),
        .ack_o        (ack_o)
    );

    // targets -------------------------------
    // cyc, we, addr, sel and wdata go to every target unchanged
    sim_mem #(
        .BASE    (DMEM_BASE),
        .SIZE    (DMEM_SIZE),
        .LATENCY (DMEM_LATENCY)
    ) i_dmem (
        .clk_gen (clk_gen),
        .rst_gen (rst_gen),
        .cyc_i   (cyc_i),
        .stb_i   (dmem_stb),
        .we_i    (we_i),
        .addr_i  (addr_i),
        .sel_i   (sel_i),
        .wdata_i (wdata_i),
        .rdata_o (dmem_rdata),
        .ack_o   (dmem_ack)
    );

    sim_mem #(
        .BASE    (IO_BASE),
        .SIZE    (IO_SIZE),
        .LATENCY (IO_LATENCY)
    ) i_iomem (
        .clk_gen (clk_gen),
        .rst_gen (rst_gen),
        .cyc_i   (cyc_i),
        .stb_i   (io_stb),
        .we_i    (we_i),
        .addr_i  (addr_i),
        .sel_i   (sel_i),
        .wdata_i (wdata_i),
        .rdata_o (io_rdata),
        .ack_o   (io_ack)
    );

    irq_trigger i_irq (
        .clk_gen (clk_gen),
        .rst_gen (rst_gen),
        .cyc_i   (cyc_i),
        .stb_i   (irq_stb),
        .we_i    (we_i),
        .sel_i   (sel_i),
        .wdata_i (wdata_i),
        .rdata_o (irq_rdata),
        .ack_o   (irq_ack),
        .msi_o   (msi_o),
        .mei_o   (mei_o)
    );

endmodule : wb_sim_fabric_top
